/* design/ctrlReg_defines.svh */
`ifndef CTRLREG_DEFINES_SVH
`define CTRLREG_DEFINES_SVH

// register id width
`define CR_ID_WIDTH 5
// full data word
`define CR_WORD_WIDTH 64
// address registers hold the low part of a word
`define CR_ADDR_WIDTH 48
// fp status rides in the top of gbr
`define CR_FPSR_WIDTH 16

// sr bit positions
`define CR_SR_MODE_BIT 30
`define CR_SR_TRAP_BIT 28

// pc step per advancing cycle
`define CR_PC_STEP 4

`endif

/* design/ctrlRegPkg.sv */
`include "ctrlReg_defines.svh"

package ctrlRegPkg;

	typedef logic [`CR_ID_WIDTH-1:0] crId;
	typedef logic [`CR_WORD_WIDTH-1:0] crWord;
	typedef logic [`CR_ADDR_WIDTH-1:0] crAddr;
	typedef logic [`CR_FPSR_WIDTH-1:0] fpsrWord;

	// control register ids
	localparam crId CR_PC = 5'd0;
	localparam crId CR_LR = 5'd1;
	localparam crId CR_SR = 5'd2;
	localparam crId CR_EXSR = 5'd3;
	localparam crId CR_SPC = 5'd4;
	localparam crId CR_SSP = 5'd5;
	localparam crId CR_VBR = 5'd6;
	localparam crId CR_GBR = 5'd7;
	localparam crId CR_TBR = 5'd8;
	localparam crId CR_TEA = 5'd9;
	localparam crId CR_MMCR = 5'd10;
	localparam crId CR_KRR = 5'd11;
	// immediate source, reads zero, never forwarded
	localparam crId CR_IMM = 5'd30;
	// null destination, no write
	localparam crId CR_ZZR = 5'd31;

	// pending write in an execute stage
	typedef struct packed {
		crId id;
		crWord value;
	} crWrite;

	// next values from the trap sequencer
	typedef struct packed {
		crAddr pc;
		crAddr spc;
		crAddr ssp;
		crWord lr;
		crWord sr;
		crWord exsr;
		crWord tea;
		fpsrWord fpsr;
	} crLive;

	// committed register contents
	typedef struct packed {
		crAddr pc;
		crAddr spc;
		crAddr ssp;
		crAddr vbr;
		crAddr gbr;
		crAddr tbr;
		crWord lr;
		crWord sr;
		crWord exsr;
		crWord tea;
		crWord mmcr;
		crWord krr;
		fpsrWord fpsr;
	} crView;

	typedef enum logic {
		trapIdle,
		trapActive
	} trapState;

endpackage

/* design/writePipe.sv */
module writePipe (
	input logic clock,
	input logic reset,
	input logic hold,
	input ctrlRegPkg::crWrite issue,
	input logic ex1Flush,
	input logic ex2Flush,
	input logic ex3Flush,
	output ctrlRegPkg::crWrite stage1,
	output ctrlRegPkg::crWrite stage2,
	output ctrlRegPkg::crWrite stage3
);

	// pending writes for ex1, ex2, ex3
	ctrlRegPkg::crWrite stage1Reg;
	ctrlRegPkg::crWrite stage2Reg;
	ctrlRegPkg::crWrite stage3Reg;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			// empty pipe, every slot is a null write
			stage1Reg <= '{id: ctrlRegPkg::CR_ZZR, value: '0};
			stage2Reg <= '{id: ctrlRegPkg::CR_ZZR, value: '0};
			stage3Reg <= '{id: ctrlRegPkg::CR_ZZR, value: '0};
		end
		else if (!hold)
		begin
			stage1Reg <= issue;
			// ex1 flush kills the write on its way to ex2
			stage2Reg <= stage1Reg;
			if (ex1Flush)
			begin
				stage2Reg.id <= ctrlRegPkg::CR_ZZR;
			end
			// same for ex2 into ex3
			stage3Reg <= stage2Reg;
			if (ex2Flush)
			begin
				stage3Reg.id <= ctrlRegPkg::CR_ZZR;
			end
		end
	end

	// forwarding taps
	assign stage1 = stage1Reg;
	assign stage2 = stage2Reg;

	// ex3 flush kills the commit in place
	always_comb
	begin
		stage3 = stage3Reg;
		if (ex3Flush)
		begin
			stage3.id = ctrlRegPkg::CR_ZZR;
		end
	end

endmodule

/* design/trapSequencer.sv */
`include "ctrlReg_defines.svh"

module trapSequencer (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic trapRequest,
	input logic returnRequest,
	input ctrlRegPkg::crWord trapCause,
	input ctrlRegPkg::crView view,
	output ctrlRegPkg::crLive live
);

	ctrlRegPkg::trapState state;
	logic trapEnter;
	logic trapReturn;

	// requests only count in the matching state
	assign trapEnter = trapRequest && (state == ctrlRegPkg::trapIdle);
	assign trapReturn = returnRequest && (state == ctrlRegPkg::trapActive);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= ctrlRegPkg::trapIdle;
		end
		else if (!hold)
		begin
			// hold freezes the state too
			if (trapEnter)
			begin
				state <= ctrlRegPkg::trapActive;
			end
			else if (trapReturn)
			begin
				state <= ctrlRegPkg::trapIdle;
			end
		end
	end

	always_comb
	begin
		// normal flow, everything carries over
		live.pc = view.pc + ctrlRegPkg::crAddr'(`CR_PC_STEP);
		live.spc = view.spc;
		live.ssp = view.ssp;
		live.lr = view.lr;
		live.sr = view.sr;
		live.exsr = view.exsr;
		live.tea = view.tea;
		live.fpsr = view.fpsr;

		if (trapEnter)
		begin
			// save return point and status
			live.spc = view.pc;
			live.exsr = view.sr;
			// flag the trap in sr
			live.sr = view.sr;
			live.sr[`CR_SR_TRAP_BIT] = 1'b1;
			live.tea = trapCause;
			// vector through vbr
			live.pc = view.vbr;
		end
		else if (trapReturn)
		begin
			// back to the saved point
			live.pc = view.spc;
			live.sr = view.exsr;
		end
	end

endmodule

/* design/ctrlRegFile.sv */
`include "ctrlReg_defines.svh"

module ctrlRegFile (
	input logic clock,
	input logic reset,
	input logic hold,
	input ctrlRegPkg::crWrite stage1,
	input ctrlRegPkg::crWrite stage2,
	input ctrlRegPkg::crWrite stage3,
	input ctrlRegPkg::crLive live,
	input ctrlRegPkg::crId readId,
	output ctrlRegPkg::crWord readValue,
	output ctrlRegPkg::crView view
);

	// sr after reset, supervisor only
	localparam ctrlRegPkg::crWord srResetValue =
		ctrlRegPkg::crWord'(1) << `CR_SR_MODE_BIT;

	ctrlRegPkg::crView viewReg;

	// commit slot, already cleared by an ex3 flush
	ctrlRegPkg::crId commitId;
	ctrlRegPkg::crWord commitValue;
	ctrlRegPkg::crAddr commitAddr;
	ctrlRegPkg::fpsrWord commitHigh;

	// stored value for the read port
	ctrlRegPkg::crWord storedValue;
	logic forwardable;

	function automatic ctrlRegPkg::crWord zeroExtend(input ctrlRegPkg::crAddr addr);
		return ctrlRegPkg::crWord'(addr);
	endfunction

	assign commitId = stage3.id;
	assign commitValue = stage3.value;
	// address registers keep the low part
	assign commitAddr = stage3.value[`CR_ADDR_WIDTH-1:0];
	// top bits of a gbr write go to fpsr
	assign commitHigh = stage3.value[`CR_WORD_WIDTH-1:`CR_ADDR_WIDTH];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			viewReg <= '0;
			viewReg.sr <= srResetValue;
		end
		else if (!hold)
		begin
			// pc only follows the sequencer
			viewReg.pc <= live.pc;

			// live-updated, a commit wins
			viewReg.sr <= (commitId == ctrlRegPkg::CR_SR) ? commitValue : live.sr;
			viewReg.exsr <= (commitId == ctrlRegPkg::CR_EXSR) ? commitValue : live.exsr;
			viewReg.lr <= (commitId == ctrlRegPkg::CR_LR) ? commitValue : live.lr;
			viewReg.tea <= (commitId == ctrlRegPkg::CR_TEA) ? commitValue : live.tea;
			viewReg.spc <= (commitId == ctrlRegPkg::CR_SPC) ? commitAddr : live.spc;
			viewReg.ssp <= (commitId == ctrlRegPkg::CR_SSP) ? commitAddr : live.ssp;

			// written only by commit
			if (commitId == ctrlRegPkg::CR_VBR)
			begin
				viewReg.vbr <= commitAddr;
			end
			if (commitId == ctrlRegPkg::CR_TBR)
			begin
				viewReg.tbr <= commitAddr;
			end
			if (commitId == ctrlRegPkg::CR_MMCR)
			begin
				viewReg.mmcr <= commitValue;
			end
			if (commitId == ctrlRegPkg::CR_KRR)
			begin
				viewReg.krr <= commitValue;
			end

			// gbr write also sets fpsr
			if (commitId == ctrlRegPkg::CR_GBR)
			begin
				viewReg.gbr <= commitAddr;
				viewReg.fpsr <= commitHigh;
			end
			else
			begin
				viewReg.fpsr <= live.fpsr;
			end
		end
	end

	assign view = viewReg;

	always_comb
	begin
		forwardable = 1'b1;
		case (readId)
			ctrlRegPkg::CR_PC: storedValue = zeroExtend(viewReg.pc);
			ctrlRegPkg::CR_LR: storedValue = viewReg.lr;
			ctrlRegPkg::CR_SR: storedValue = viewReg.sr;
			ctrlRegPkg::CR_EXSR: storedValue = viewReg.exsr;
			ctrlRegPkg::CR_SPC: storedValue = zeroExtend(viewReg.spc);
			ctrlRegPkg::CR_SSP: storedValue = zeroExtend(viewReg.ssp);
			ctrlRegPkg::CR_VBR: storedValue = zeroExtend(viewReg.vbr);
			// fpsr sits above gbr
			ctrlRegPkg::CR_GBR: storedValue = {viewReg.fpsr, viewReg.gbr};
			ctrlRegPkg::CR_TBR: storedValue = zeroExtend(viewReg.tbr);
			ctrlRegPkg::CR_TEA: storedValue = viewReg.tea;
			ctrlRegPkg::CR_MMCR: storedValue = viewReg.mmcr;
			ctrlRegPkg::CR_KRR: storedValue = viewReg.krr;
			default:
			begin
				// imm, zzr and unused ids read zero
				storedValue = '0;
				forwardable = 1'b0;
			end
		endcase

		// newest pending write wins, raw value
		readValue = storedValue;
		if (forwardable)
		begin
			if (stage3.id == readId)
			begin
				readValue = stage3.value;
			end
			if (stage2.id == readId)
			begin
				readValue = stage2.value;
			end
			if (stage1.id == readId)
			begin
				readValue = stage1.value;
			end
		end
	end

endmodule

/* design/ctrlSubsystem.sv */
module ctrlSubsystem (
	input logic clock,
	input logic reset,
	input logic hold,
	input ctrlRegPkg::crWrite issue,
	input logic ex1Flush,
	input logic ex2Flush,
	input logic ex3Flush,
	input logic trapRequest,
	input ctrlRegPkg::crWord trapCause,
	input logic returnRequest,
	input ctrlRegPkg::crId readId,
	output ctrlRegPkg::crWord readValue,
	output ctrlRegPkg::crView view
);

	// execute stage taps
	ctrlRegPkg::crWrite stage1;
	ctrlRegPkg::crWrite stage2;
	ctrlRegPkg::crWrite stage3;
	// sequencer next values
	ctrlRegPkg::crLive live;

	writePipe u_writePipe (
		.clock, .reset, .hold,
		.issue,
		.ex1Flush, .ex2Flush, .ex3Flush,
		.stage1, .stage2, .stage3
	);

	trapSequencer u_trapSequencer (
		.clock, .reset, .hold,
		.trapRequest, .returnRequest, .trapCause,
		.view,
		.live
	);

	ctrlRegFile u_ctrlRegFile (
		.clock, .reset, .hold,
		.stage1, .stage2, .stage3,
		.live,
		.readId, .readValue,
		.view
	);

endmodule

/* bench/ctrlSubsystem_chk.sv */
`include "ctrlReg_defines.svh"

module ctrlSubsystem_chk (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic ex3Flush,
	input ctrlRegPkg::crView view
);
	timeunit 1ns;
	timeprecision 100ps;

	// a held edge leaves every register alone
	holdFreezesView: assert property (@(posedge clock) disable iff (reset)
		hold |=> $stable(view))
	else $error("view changed across a held edge");

	// supervisor mode only after reset
	srAfterReset: assert property (@(posedge clock)
		reset |=> view.sr == (64'd1 << `CR_SR_MODE_BIT))
	else $error("sr is not the mode bit alone after reset");

	// killed ex3 slot never reaches the commit-only registers
	flushedNoCommit: assert property (@(posedge clock) disable iff (reset)
		ex3Flush && !hold |=> $stable(view.vbr) && $stable(view.gbr)
			&& $stable(view.tbr) && $stable(view.mmcr) && $stable(view.krr)
			&& $stable(view.fpsr))
	else $error("a write flushed in ex3 still reached a register");

endmodule

bind ctrlSubsystem ctrlSubsystem_chk u_ctrlSubsystem_chk (
	.clock, .reset, .hold, .ex3Flush, .view
);

/* bench/ctrlSubsystemTb.sv */
`include "ctrlReg_defines.svh"

module ctrlSubsystemTb;
	timeunit 1ns;
	timeprecision 100ps;

	// about 1,150 cycles of stimulus, plus margin
	localparam int cycleLimit = 2000;
	localparam ctrlRegPkg::crWrite nullWrite = '{id: ctrlRegPkg::CR_ZZR, value: '0};

	logic clock;
	logic reset;
	logic hold;
	ctrlRegPkg::crWrite issue;
	logic ex1Flush;
	logic ex2Flush;
	logic ex3Flush;
	logic trapRequest;
	ctrlRegPkg::crWord trapCause;
	logic returnRequest;
	ctrlRegPkg::crId readId;
	ctrlRegPkg::crWord readValue;
	ctrlRegPkg::crView view;

	// model state, stages indexed 1 to 3
	ctrlRegPkg::crView modelView;
	ctrlRegPkg::crWrite modelStage [1:3];
	logic modelActive;
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	ctrlSubsystem u_ctrlSubsystem (.*);

	// read port as the model sees it
	function automatic ctrlRegPkg::crWord expectedRead(input ctrlRegPkg::crId id);
		ctrlRegPkg::crWord r;
		case (id)
			ctrlRegPkg::CR_PC: r = 64'(modelView.pc);
			ctrlRegPkg::CR_LR: r = modelView.lr;
			ctrlRegPkg::CR_SR: r = modelView.sr;
			ctrlRegPkg::CR_EXSR: r = modelView.exsr;
			ctrlRegPkg::CR_SPC: r = 64'(modelView.spc);
			ctrlRegPkg::CR_SSP: r = 64'(modelView.ssp);
			ctrlRegPkg::CR_VBR: r = 64'(modelView.vbr);
			// fpsr shows above gbr
			ctrlRegPkg::CR_GBR: r = {modelView.fpsr, modelView.gbr};
			ctrlRegPkg::CR_TBR: r = 64'(modelView.tbr);
			ctrlRegPkg::CR_TEA: r = modelView.tea;
			ctrlRegPkg::CR_MMCR: r = modelView.mmcr;
			ctrlRegPkg::CR_KRR: r = modelView.krr;
			default: r = '0;
		endcase
		// pending writes, oldest first so the newest wins
		if (id <= ctrlRegPkg::CR_KRR)
		begin
			for (int s = 3; s >= 1; s--)
			begin
				if (modelStage[s].id == id && !(s == 3 && ex3Flush))
				begin
					r = modelStage[s].value;
				end
			end
		end
		return r;
	endfunction

	// register contents after one advancing edge
	function automatic ctrlRegPkg::crView nextView(input ctrlRegPkg::crView v,
		input ctrlRegPkg::crWrite w, input logic enter, input logic leave);
		ctrlRegPkg::crView n;
		n = v;
		n.pc = v.pc + 48'(`CR_PC_STEP);
		if (enter)
		begin
			n.spc = v.pc;
			n.exsr = v.sr;
			n.sr[`CR_SR_TRAP_BIT] = 1'b1;
			n.tea = trapCause;
			n.pc = v.vbr;
		end
		else if (leave)
		begin
			n.pc = v.spc;
			n.sr = v.exsr;
		end
		// ex3 commit beats the live value
		case (w.id)
			ctrlRegPkg::CR_LR: n.lr = w.value;
			ctrlRegPkg::CR_SR: n.sr = w.value;
			ctrlRegPkg::CR_EXSR: n.exsr = w.value;
			ctrlRegPkg::CR_SPC: n.spc = w.value[`CR_ADDR_WIDTH-1:0];
			ctrlRegPkg::CR_SSP: n.ssp = w.value[`CR_ADDR_WIDTH-1:0];
			ctrlRegPkg::CR_VBR: n.vbr = w.value[`CR_ADDR_WIDTH-1:0];
			ctrlRegPkg::CR_TBR: n.tbr = w.value[`CR_ADDR_WIDTH-1:0];
			ctrlRegPkg::CR_TEA: n.tea = w.value;
			ctrlRegPkg::CR_MMCR: n.mmcr = w.value;
			ctrlRegPkg::CR_KRR: n.krr = w.value;
			// top 16 bits land in fpsr
			ctrlRegPkg::CR_GBR: {n.fpsr, n.gbr} = w.value;
			default: n = n;
		endcase
		return n;
	endfunction

	task automatic checkWord(input string name, input ctrlRegPkg::crWord actual,
		input ctrlRegPkg::crWord expected);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errorCount++;
			$display("error at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// one cycle of inputs on the falling edge
	task automatic applyCycle(input logic holdIn, input ctrlRegPkg::crId id,
		input logic [2:0] flush, input logic trap, input logic leave, input ctrlRegPkg::crId rid);
		@(negedge clock);
		hold = holdIn;
		issue.id = id;
		issue.value = {$urandom, $urandom};
		{ex3Flush, ex2Flush, ex1Flush} = flush;
		trapRequest = trap;
		returnRequest = leave;
		trapCause = {$urandom, $urandom};
		readId = rid;
	endtask

	task automatic idleCycles(input int n, input ctrlRegPkg::crId rid);
		repeat (n) applyCycle(1'b0, ctrlRegPkg::CR_ZZR, 3'b000, 1'b0, 1'b0, rid);
	endtask

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// check before the edge, then step the model
	always @(posedge clock)
	begin
		ctrlRegPkg::crWrite commit;
		logic enter;
		logic leave;
		if (reset)
		begin
			modelView = '0;
			modelView.sr[`CR_SR_MODE_BIT] = 1'b1;
			modelStage = '{nullWrite, nullWrite, nullWrite};
			modelActive = 1'b0;
		end
		else
		begin
			checkWord("readValue", readValue, expectedRead(readId));
			checkWord("view.pc", 64'(view.pc), 64'(modelView.pc));
			checkWord("view.spc", 64'(view.spc), 64'(modelView.spc));
			checkWord("view.ssp", 64'(view.ssp), 64'(modelView.ssp));
			checkWord("view.vbr", 64'(view.vbr), 64'(modelView.vbr));
			checkWord("view.gbr", 64'(view.gbr), 64'(modelView.gbr));
			checkWord("view.tbr", 64'(view.tbr), 64'(modelView.tbr));
			checkWord("view.lr", view.lr, modelView.lr);
			checkWord("view.sr", view.sr, modelView.sr);
			checkWord("view.exsr", view.exsr, modelView.exsr);
			checkWord("view.tea", view.tea, modelView.tea);
			checkWord("view.mmcr", view.mmcr, modelView.mmcr);
			checkWord("view.krr", view.krr, modelView.krr);
			checkWord("view.fpsr", 64'(view.fpsr), 64'(modelView.fpsr));
			// held edges change nothing
			if (!hold)
			begin
				enter = trapRequest && !modelActive;
				leave = returnRequest && modelActive;
				commit = modelStage[3];
				commit.id = ex3Flush ? ctrlRegPkg::CR_ZZR : commit.id;
				modelView = nextView(modelView, commit, enter, leave);
				modelActive = (modelActive || enter) && !leave;
				modelStage[3] = modelStage[2];
				modelStage[3].id = ex2Flush ? ctrlRegPkg::CR_ZZR : modelStage[2].id;
				modelStage[2] = modelStage[1];
				modelStage[2].id = ex1Flush ? ctrlRegPkg::CR_ZZR : modelStage[1].id;
				modelStage[1] = issue;
			end
		end
	end

	// run limit
	initial
	begin
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", cycleLimit);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		ctrlRegPkg::crId target;
		void'($urandom(32'hfb76));
		reset = 1'b1;
		hold = 1'b0;
		issue = nullWrite;
		ex1Flush = 1'b0;
		ex2Flush = 1'b0;
		ex3Flush = 1'b0;
		trapRequest = 1'b0;
		trapCause = '0;
		returnRequest = 1'b0;
		readId = ctrlRegPkg::CR_ZZR;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// pc counts up from zero, null and imm read zero
		idleCycles(2, ctrlRegPkg::CR_ZZR);
		idleCycles(2, ctrlRegPkg::CR_IMM);
		// imm in the pipe is never forwarded
		applyCycle(1'b0, ctrlRegPkg::CR_IMM, 3'b000, 1'b0, 1'b0, ctrlRegPkg::CR_IMM);
		idleCycles(3, ctrlRegPkg::CR_IMM);
		idleCycles(3, ctrlRegPkg::CR_PC);

		// each writable register, read through bypass then view
		for (int id = 1; id <= 11; id++)
		begin
			target = ctrlRegPkg::crId'(id);
			applyCycle(1'b0, target, 3'b000, 1'b0, 1'b0, target);
			idleCycles(4, target);
		end
		// back to back gbr writes
		repeat (3) applyCycle(1'b0, ctrlRegPkg::CR_GBR, 3'b000, 1'b0, 1'b0, ctrlRegPkg::CR_GBR);
		idleCycles(4, ctrlRegPkg::CR_GBR);

		// krr write killed in ex1, ex2, ex3 in turn
		for (int s = 0; s < 3; s++)
		begin
			applyCycle(1'b0, ctrlRegPkg::CR_KRR, 3'b000, 1'b0, 1'b0, ctrlRegPkg::CR_KRR);
			idleCycles(s, ctrlRegPkg::CR_KRR);
			applyCycle(1'b0, ctrlRegPkg::CR_ZZR, 3'b001 << s, 1'b0, 1'b0, ctrlRegPkg::CR_KRR);
			idleCycles(4, ctrlRegPkg::CR_KRR);
		end

		// trap via vbr, second trap ignored, return, second return ignored
		applyCycle(1'b0, ctrlRegPkg::CR_VBR, 3'b000, 1'b0, 1'b0, ctrlRegPkg::CR_VBR);
		idleCycles(4, ctrlRegPkg::CR_SPC);
		applyCycle(1'b0, ctrlRegPkg::CR_ZZR, 3'b000, 1'b1, 1'b0, ctrlRegPkg::CR_TEA);
		applyCycle(1'b0, ctrlRegPkg::CR_ZZR, 3'b000, 1'b1, 1'b0, ctrlRegPkg::CR_EXSR);
		idleCycles(3, ctrlRegPkg::CR_SR);
		applyCycle(1'b0, ctrlRegPkg::CR_ZZR, 3'b000, 1'b0, 1'b1, ctrlRegPkg::CR_PC);
		applyCycle(1'b0, ctrlRegPkg::CR_ZZR, 3'b000, 1'b0, 1'b1, ctrlRegPkg::CR_SR);
		// held trap request and write
		repeat (3) applyCycle(1'b1, ctrlRegPkg::CR_LR, 3'b000, 1'b1, 1'b0, ctrlRegPkg::CR_LR);
		idleCycles(3, ctrlRegPkg::CR_PC);

		// random hold, writes, flushes, traps
		for (int n = 0; n < 1000; n++)
		begin
			r = $urandom;
			applyCycle(r[12:10] == 3'd0, r[4:0], r[15:13] & r[18:16] & r[21:19],
				r[25:22] == 4'd0, r[29:26] == 4'd0, r[9:5]);
		end
		idleCycles(4, ctrlRegPkg::CR_ZZR);

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+design
design/ctrlRegPkg.sv
design/writePipe.sv
design/trapSequencer.sv
design/ctrlRegFile.sv
design/ctrlSubsystem.sv
bench/ctrlSubsystem_chk.sv
bench/ctrlSubsystemTb.sv

/* Makefile */
# simulator, options, top and sources
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := ctrlSubsystemTb
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS     := TESTS PASSED

.PHONY: all compile run clean

all: run

# build the simulation binary
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# run into the log, then look for the pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
